//--- hdl/shadow_consts.svh
`ifndef SHADOW_CONSTS_SVH
`define SHADOW_CONSTS_SVH

// Primitive addressing
`define SHDW_PRIM_INDEX_WIDTH   12
`define SHDW_PRIM_COUNT_WIDTH   8

// Primitives per any-hit test batch
`define SHDW_TEST_UNIT_SIZE     4
`define SHDW_TEST_UNIT_WIDTH    2

// Group queue sizing
`define SHDW_GROUP_QUEUE_DEPTH  16
`define SHDW_GROUP_PTR_WIDTH    4

// Fixed group searched for every lit fragment
`define SHDW_EXTRA_PRIM_BASE    4088
`define SHDW_EXTRA_PRIM_COUNT   3

// Fragment fields
`define SHDW_PIXEL_COORD_WIDTH  11
`define SHDW_BOUNCE_WIDTH       3
`define SHDW_PAYLOAD_WIDTH      32

`endif

//--- hdl/shadowPkg.sv
`include "shadow_consts.svh"

package shadowPkg;

    // -----------------------------------------------------------
    // Scalar widths
    // -----------------------------------------------------------
    typedef logic [`SHDW_PRIM_INDEX_WIDTH-1:0]  primIndexT;
    typedef logic [`SHDW_PRIM_COUNT_WIDTH-1:0]  primCountT;
    typedef logic [`SHDW_PIXEL_COORD_WIDTH-1:0] pixelCoordT;
    typedef logic [`SHDW_BOUNCE_WIDTH-1:0]      bounceT;
    typedef logic [`SHDW_PAYLOAD_WIDTH-1:0]     payloadT;
    typedef logic [`SHDW_GROUP_PTR_WIDTH-1:0]   groupPtrT;

    typedef enum logic [1:0] {
        surfNone,
        surfDiffuse,
        surfSpecular
    } surfaceT;

    // -----------------------------------------------------------
    // Primitive groups
    // -----------------------------------------------------------
    typedef struct packed {
        primIndexT start;
        primCountT count;
    } primGroupT;

    // Zero count marks an empty leaf
    typedef struct packed {
        primGroupT leaf1;
        primGroupT leaf0;
    } leafPairT;

    // -----------------------------------------------------------
    // Fragments
    // -----------------------------------------------------------
    typedef struct packed {
        pixelCoordT x;
        pixelCoordT y;
        surfaceT    surface;
        bounceT     bounce;
        payloadT    payload;
    } fragmentT;

    typedef struct packed {
        fragmentT frag;
        logic     inShadow;
    } shadedFragmentT;

    typedef enum logic [1:0] {
        stIdle,
        stSearch,
        stDone
    } shadowStateT;

endpackage

//--- hdl/groupQueue.sv
`include "shadow_consts.svh"

module groupQueue import shadowPkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      clearSearch,
    input  logic      pushExtra,
    input  logic      leafValid,
    input  leafPairT  leaves,
    input  logic      pop,
    output primGroupT head,
    output logic      queueEmpty
);

    localparam int maxWrites = 3;

    localparam primGroupT extraGroup = '{
        start: primIndexT'(`SHDW_EXTRA_PRIM_BASE),
        count: primCountT'(`SHDW_EXTRA_PRIM_COUNT)
    };

    primGroupT groups [`SHDW_GROUP_QUEUE_DEPTH];
    groupPtrT  headPtr;
    groupPtrT  tailPtr;

    primGroupT wrData [maxWrites];
    logic [1:0] wrCount;

    // -----------------------------------------------------------
    // Pack this cycle's groups in order: extra, leaf0, leaf1
    // -----------------------------------------------------------
    always_comb begin
        wrCount = '0;
        wrData = '{default: '0};
        if (pushExtra) begin
            wrData[wrCount] = extraGroup;
            wrCount = wrCount + 2'd1;
        end
        if (leafValid && leaves.leaf0.count != '0) begin
            wrData[wrCount] = leaves.leaf0;
            wrCount = wrCount + 2'd1;
        end
        if (leafValid && leaves.leaf1.count != '0) begin
            wrData[wrCount] = leaves.leaf1;
            wrCount = wrCount + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < maxWrites; i++) begin
            if (!clearSearch && i < int'(wrCount)) begin
                groups[tailPtr + groupPtrT'(i)] <= wrData[i];
            end
        end
    end

    // Pointers
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else if (clearSearch) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else begin
            tailPtr <= tailPtr + groupPtrT'(wrCount);
            if (pop) begin
                headPtr <= headPtr + groupPtrT'(1);
            end
        end
    end

    assign head = groups[headPtr];
    assign queueEmpty = (headPtr == tailPtr);

endmodule

//--- hdl/batchWalker.sv
`include "shadow_consts.svh"

module batchWalker import shadowPkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      clearSearch,
    input  primGroupT head,
    input  logic      queueEmpty,
    output logic      pop,
    output logic      batchValid,
    output primIndexT batchStart,
    output primIndexT batchEnd,
    output logic      walkerIdle
);

    primIndexT countExt;
    primIndexT alignedCount;
    primIndexT alignedEnd;
    primIndexT nextStart;

    // -----------------------------------------------------------
    // Round the group size up to whole test units
    // -----------------------------------------------------------
    always_comb begin
        countExt = primIndexT'(head.count);
        alignedCount = countExt;
        if (countExt[`SHDW_TEST_UNIT_WIDTH-1:0] != '0) begin
            alignedCount = ((countExt >> `SHDW_TEST_UNIT_WIDTH) + primIndexT'(1))
                           << `SHDW_TEST_UNIT_WIDTH;
        end
    end

    assign nextStart = batchStart + primIndexT'(`SHDW_TEST_UNIT_SIZE);

    // Fetch a new group only while searching and idle
    assign pop = !batchValid && !queueEmpty && !clearSearch;
    assign walkerIdle = !batchValid;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            batchValid <= 1'b0;
        end else if (clearSearch) begin
            batchValid <= 1'b0;
        end else if (pop) begin
            batchValid <= (head.count != '0);
        end else if (batchValid && nextStart == alignedEnd) begin
            // Last batch of this group
            batchValid <= 1'b0;
        end
    end

    // Batch bounds, batchEnd stays at the real group end
    always_ff @(posedge clk) begin
        if (pop) begin
            batchStart <= head.start;
            batchEnd <= head.start + countExt;
            alignedEnd <= head.start + alignedCount;
        end else if (batchValid) begin
            batchStart <= nextStart;
        end
    end

endmodule

//--- hdl/shadowControl.sv
module shadowControl import shadowPkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  logic           fragValid,
    input  fragmentT       fragIn,
    output logic           fifoFull,
    input  logic           outFull,
    output logic           outValid,
    output shadedFragmentT shadeOut,
    output logic           traversalStart,
    output logic           traversalRestart,
    input  logic           traversalDone,
    input  logic           queueEmpty,
    input  logic           walkerIdle,
    input  logic           batchValid,
    input  logic           batchHit,
    output logic           pushExtra,
    output logic           clearSearch
);

    shadowStateT state;

    fragmentT slot;
    fragmentT current;
    logic     inShadow;
    logic     searchStart;

    logic accept;
    logic take;
    logic hitFound;
    logic searchOver;
    logic emit;

    // -----------------------------------------------------------
    // Handshake and search conditions
    // -----------------------------------------------------------
    assign accept = fragValid && !fifoFull;
    assign take = (state == stIdle) && fifoFull;
    assign emit = (state == stDone) && !outFull;
    assign hitFound = batchValid && batchHit;

    // Nothing left once traversal is done and all groups are walked
    assign searchOver = walkerIdle && queueEmpty && traversalDone && !searchStart;

    // Queue and walker stay flushed outside an active search
    assign clearSearch = (state != stSearch) || hitFound;

    assign traversalStart = searchStart;
    assign pushExtra = searchStart;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= stIdle;
            fifoFull <= 1'b0;
            inShadow <= 1'b0;
            searchStart <= 1'b0;
            outValid <= 1'b0;
            traversalRestart <= 1'b0;
        end else begin
            searchStart <= 1'b0;
            outValid <= 1'b0;
            traversalRestart <= 1'b0;

            // Single entry input slot
            if (accept) begin
                fifoFull <= 1'b1;
            end else if (take) begin
                fifoFull <= 1'b0;
            end

            case (state)
                stIdle: begin
                    if (fifoFull) begin
                        inShadow <= 1'b0;
                        if (slot.surface == surfNone) begin
                            state <= stDone;
                        end else begin
                            searchStart <= 1'b1;
                            state <= stSearch;
                        end
                    end
                end
                stSearch: begin
                    if (hitFound) begin
                        // First hit ends the search
                        inShadow <= 1'b1;
                        state <= stDone;
                    end else if (searchOver) begin
                        state <= stDone;
                    end
                end
                stDone: begin
                    if (!outFull) begin
                        outValid <= 1'b1;
                        traversalRestart <= 1'b1;
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Fragment data path
    always_ff @(posedge clk) begin
        if (accept) begin
            slot <= fragIn;
        end
        if (take) begin
            current <= slot;
        end
        if (emit) begin
            shadeOut <= '{frag: current, inShadow: inShadow};
        end
    end

endmodule

//--- hdl/shadowUnit.sv
module shadowUnit import shadowPkg::*; (
    input  logic           clk,
    input  logic           resetn,
    input  logic           fragValid,
    input  fragmentT       fragIn,
    output logic           fifoFull,
    input  logic           outFull,
    output logic           outValid,
    output shadedFragmentT shadeOut,
    output logic           traversalStart,
    output logic           traversalRestart,
    input  logic           leafValid,
    input  leafPairT       leaves,
    input  logic           traversalDone,
    output logic           batchValid,
    output primIndexT      batchStart,
    output primIndexT      batchEnd,
    input  logic           batchHit
);

    logic      pushExtra;
    logic      clearSearch;
    logic      queueEmpty;
    logic      walkerIdle;
    logic      pop;
    primGroupT head;

    // -----------------------------------------------------------
    // Controller
    // -----------------------------------------------------------
    shadowControl control (
        .clk(clk),
        .resetn(resetn),
        .fragValid(fragValid),
        .fragIn(fragIn),
        .fifoFull(fifoFull),
        .outFull(outFull),
        .outValid(outValid),
        .shadeOut(shadeOut),
        .traversalStart(traversalStart),
        .traversalRestart(traversalRestart),
        .traversalDone(traversalDone),
        .queueEmpty(queueEmpty),
        .walkerIdle(walkerIdle),
        .batchValid(batchValid),
        .batchHit(batchHit),
        .pushExtra(pushExtra),
        .clearSearch(clearSearch)
    );

    // Candidate groups from traversal
    groupQueue queue (
        .clk(clk),
        .resetn(resetn),
        .clearSearch(clearSearch),
        .pushExtra(pushExtra),
        .leafValid(leafValid),
        .leaves(leaves),
        .pop(pop),
        .head(head),
        .queueEmpty(queueEmpty)
    );

    // Batches for the any-hit tester
    batchWalker walker (
        .clk(clk),
        .resetn(resetn),
        .clearSearch(clearSearch),
        .head(head),
        .queueEmpty(queueEmpty),
        .pop(pop),
        .batchValid(batchValid),
        .batchStart(batchStart),
        .batchEnd(batchEnd),
        .walkerIdle(walkerIdle)
    );

endmodule

//--- bench/tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// -----------------------------------------------------------
// Checking and reporting
// -----------------------------------------------------------
task automatic checkValues(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        errorCount++;
    end
endtask

task automatic reportFailure(input string what);
    $display("Failure: %s", what);
    errorCount++;
endtask

function automatic int totalErrors();
    return errorCount + monitorErrors;
endfunction

task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (totalErrors() == errorsBefore) begin
        $display("Test %s passed", name);
    end else begin
        testsFailed++;
        $display("Test %s failed with %0d errors", name, totalErrors() - errorsBefore);
    end
endtask

// -----------------------------------------------------------
// Reference model
// -----------------------------------------------------------
function automatic primGroupT makeGroup(input int base, input int size);
    primGroupT g;
    g.start = primIndexT'(base);
    g.count = primCountT'(size);
    return g;
endfunction

function automatic logic coversIndex(input primGroupT g, input int idx);
    return (idx >= int'(g.start)) && (idx < int'(g.start) + int'(g.count));
endfunction

// Lit fragments search the extra group and every scripted leaf
function automatic logic expectShadow(input surfaceT surf, input int idx);
    logic hit;
    if (surf == surfNone) begin
        return 1'b0;
    end
    hit = coversIndex(makeGroup(`SHDW_EXTRA_PRIM_BASE, `SHDW_EXTRA_PRIM_COUNT), idx);
    foreach (leafScript[i]) begin
        hit = hit | coversIndex(leafScript[i].leaf0, idx) | coversIndex(leafScript[i].leaf1, idx);
    end
    return hit;
endfunction

// Starts step by the unit size up to the count rounded up
task automatic addGroupBatches(input primGroupT g);
    int first;
    int last;
    first = int'(g.start);
    last = first + ((int'(g.count) + `SHDW_TEST_UNIT_SIZE - 1) / `SHDW_TEST_UNIT_SIZE)
           * `SHDW_TEST_UNIT_SIZE;
    for (int b = first; b < last; b += `SHDW_TEST_UNIT_SIZE) begin
        expStart.push_back(primIndexT'(b));
        expEnd.push_back(primIndexT'(first + int'(g.count)));
    end
endtask

task automatic loadTwoLeaves();
    leafPairT pair;
    pair.leaf0 = makeGroup(10, 6);
    pair.leaf1 = makeGroup(40, 1);
    leafScript.delete();
    leafScript.push_back(pair);
endtask

// -----------------------------------------------------------
// Stimulus, always entered on a falling edge
// -----------------------------------------------------------
task automatic makeFragment(input surfaceT surf, output fragmentT f);
    f.x = pixelCoordT'($random(seed));
    f.y = pixelCoordT'($random(seed));
    f.surface = surf;
    f.bounce = bounceT'($random(seed));
    f.payload = payloadT'($random(seed));
endtask

task automatic sendFragment(input fragmentT f);
    int waited;
    waited = 0;
    while (fifoFull && waited < cycleBudget) begin
        @(negedge clk);
        waited++;
    end
    if (fifoFull) begin
        reportFailure("input slot never became free");
    end else begin
        fragValid = 1'b1;
        fragIn = f;
        @(negedge clk);
        fragValid = 1'b0;
    end
endtask

task automatic waitOutputs(input int count);
    int waited;
    waited = 0;
    while (outLog.size() < count && waited < cycleBudget) begin
        @(negedge clk);
        waited++;
    end
    if (outLog.size() < count) begin
        reportFailure("no result from the DUT within the cycle budget");
    end
endtask

// -----------------------------------------------------------
// Directed tests
// -----------------------------------------------------------
task automatic testResetState();
    int errorsBefore;
    errorsBefore = totalErrors();
    checkValues("outValid", 64'(outValid), 64'd0);
    checkValues("fifoFull", 64'(fifoFull), 64'd0);
    checkValues("traversalStart", 64'(traversalStart), 64'd0);
    checkValues("traversalRestart", 64'(traversalRestart), 64'd0);
    checkValues("batchValid", 64'(batchValid), 64'd0);
    finishTest("reset state", errorsBefore);
endtask

task automatic runSearch(input string name, input surfaceT surf, input int occ,
                         input logic checkBatches);
    fragmentT       f;
    shadedFragmentT expected;
    int             errorsBefore;
    int             outMark;
    int             startMark;
    int             batchMark;
    errorsBefore = totalErrors();
    outMark = outLog.size();
    startMark = startCount;
    batchMark = startLog.size();
    occluder = occ;
    makeFragment(surf, f);
    expected = '{frag: f, inShadow: expectShadow(surf, occ)};
    sendFragment(f);
    waitOutputs(outMark + 1);
    if (outLog.size() > outMark) begin
        checkValues("shadeOut", 64'(outLog[outMark]), 64'(expected));
    end
    checkValues("traversalStart pulses", 64'(startCount - startMark),
                (surf == surfNone) ? 64'd0 : 64'd1);
    if (checkBatches) begin
        expStart.delete();
        expEnd.delete();
        if (surf != surfNone) begin
            addGroupBatches(makeGroup(`SHDW_EXTRA_PRIM_BASE, `SHDW_EXTRA_PRIM_COUNT));
            foreach (leafScript[i]) begin
                addGroupBatches(leafScript[i].leaf0);
                addGroupBatches(leafScript[i].leaf1);
            end
        end
        checkValues("batch count", 64'(startLog.size() - batchMark), 64'(expStart.size()));
        foreach (expStart[i]) begin
            if (batchMark + i < startLog.size()) begin
                checkValues("batchStart", 64'(startLog[batchMark + i]), 64'(expStart[i]));
                checkValues("batchEnd", 64'(endLog[batchMark + i]), 64'(expEnd[i]));
            end
        end
    end
    finishTest(name, errorsBefore);
endtask

task automatic testBackPressure();
    fragmentT       first;
    fragmentT       second;
    shadedFragmentT expFirst;
    shadedFragmentT expSecond;
    int             errorsBefore;
    int             outMark;
    errorsBefore = totalErrors();
    outMark = outLog.size();
    leafScript.delete();
    occluder = 4090;
    makeFragment(surfDiffuse, first);
    makeFragment(surfNone, second);
    expFirst = '{frag: first, inShadow: expectShadow(surfDiffuse, occluder)};
    expSecond = '{frag: second, inShadow: 1'b0};
    outFull = 1'b1;
    sendFragment(first);
    sendFragment(second);
    // Second fragment waits in the slot while the first is held
    repeat (30) begin
        checkValues("fifoFull", 64'(fifoFull), 64'd1);
        checkValues("results while held", 64'(outLog.size() - outMark), 64'd0);
        @(negedge clk);
    end
    outFull = 1'b0;
    waitOutputs(outMark + 2);
    repeat (5) @(negedge clk);
    checkValues("result pulses", 64'(outLog.size() - outMark), 64'd2);
    if (outLog.size() >= outMark + 2) begin
        checkValues("first shadeOut", 64'(outLog[outMark]), 64'(expFirst));
        checkValues("second shadeOut", 64'(outLog[outMark + 1]), 64'(expSecond));
    end
    finishTest("back-pressure", errorsBefore);
endtask

`endif

//--- bench/tbShadowUnit.sv
`include "shadow_consts.svh"

module tbShadowUnit import shadowPkg::*; ();

    localparam int testCount = 6;
    localparam int cycleBudget = 2000;

    logic           clk = 1'b0;
    logic           resetn;
    logic           fragValid;
    fragmentT       fragIn;
    logic           fifoFull;
    logic           outFull;
    logic           outValid;
    shadedFragmentT shadeOut;
    logic           traversalStart;
    logic           traversalRestart;
    logic           leafValid;
    leafPairT       leaves;
    logic           traversalDone;
    logic           batchValid;
    primIndexT      batchStart;
    primIndexT      batchEnd;
    logic           batchHit;

    int seed = 99050;
    int errorCount = 0;
    int monitorErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;

    // Scripted occluder (-1 for none) and leaf pairs for the traversal model
    int       occluder = -1;
    leafPairT leafScript[$];
    int       leafIndex;
    logic     traversalBusy;
    int       lastIndex;

    // Recorded DUT activity
    primIndexT      startLog[$];
    primIndexT      endLog[$];
    shadedFragmentT outLog[$];
    int             startCount = 0;
    logic           outFullAtEdge = 1'b0;
    logic           prevOutValid = 1'b0;

    // Expected batches for the current test
    primIndexT expStart[$];
    primIndexT expEnd[$];

    `include "tbTasks.svh"

    always #5 clk = ~clk;

    shadowUnit UUT (.*);

    // -----------------------------------------------------------
    // Traversal model
    // -----------------------------------------------------------
    initial begin
        leafIndex = 0;
        traversalBusy = 1'b0;
        leafValid = 1'b0;
        leaves = '0;
        traversalDone = 1'b0;
        forever begin
            @(negedge clk);
            if (traversalStart) begin
                traversalBusy = 1'b1;
                leafIndex = 0;
                leafValid = 1'b0;
                traversalDone = 1'b0;
            end else if (traversalBusy) begin
                if (leafIndex < leafScript.size()) begin
                    leaves = leafScript[leafIndex];
                    leafValid = 1'b1;
                    leafIndex++;
                end else begin
                    leafValid = 1'b0;
                    traversalDone = 1'b1;
                    traversalBusy = 1'b0;
                end
            end
        end
    end

    // Any-hit tester clipped to the real group end
    always_comb begin
        lastIndex = int'(batchStart) + `SHDW_TEST_UNIT_SIZE;
        if (int'(batchEnd) < lastIndex) begin
            lastIndex = int'(batchEnd);
        end
        batchHit = batchValid && (occluder >= int'(batchStart)) && (occluder < lastIndex);
    end

    // -----------------------------------------------------------
    // Monitor sampled mid-cycle
    // -----------------------------------------------------------
    always @(posedge clk) begin
        outFullAtEdge <= outFull;
    end

    always @(negedge clk) begin
        if (traversalStart) begin
            startCount++;
        end
        if (batchValid) begin
            startLog.push_back(batchStart);
            endLog.push_back(batchEnd);
        end
        if (traversalRestart !== outValid) begin
            $display("Failure: traversalRestart did not come together with outValid");
            monitorErrors++;
        end
        if (outValid) begin
            outLog.push_back(shadeOut);
            if (outFullAtEdge) begin
                $display("Failure: result given while outFull was high");
                monitorErrors++;
            end
            if (prevOutValid) begin
                $display("Failure: outValid stayed high for more than one cycle");
                monitorErrors++;
            end
        end
        prevOutValid = outValid;
    end

    initial begin
        #(testCount * cycleBudget * 10);
        $display("Failure: watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        resetn = 1'b0;
        fragValid = 1'b0;
        fragIn = '0;
        outFull = 1'b0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;

        testResetState();
        leafScript.delete();
        runSearch("pass-through", surfNone, -1, 1'b1);
        loadTwoLeaves();
        runSearch("no occluder", surfDiffuse, -1, 1'b1);
        runSearch("occluder in leaf", surfSpecular, 15, 1'b0);
        leafScript.delete();
        runSearch("occluder in extra group", surfDiffuse, 4090, 1'b0);
        testBackPressure();

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 testsRun, testsFailed, totalErrors());
        if (totalErrors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
+incdir+bench
hdl/shadowPkg.sv
hdl/groupQueue.sv
hdl/batchWalker.sv
hdl/shadowControl.sv
hdl/shadowUnit.sv
bench/tbShadowUnit.sv

//--- run.sh
#!/bin/sh
# Build and run the shadow unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tbShadowUnit -o simShadowUnit
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simShadowUnit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
